// ==== Bender.yml ====
package:
  name: hci_top

sources:
  - hci_pkg.sv
  - hci_queue.sv
  - hci_addr_ctrl.sv
  - hci_csr.sv
  - hci_top.sv
  - target: test
    files:
      - hci_assert.sv
      - tb_hci_top.sv

// ==== hci_addr_ctrl.sv ====
// Dynamic and virtual dynamic address registers
// Updated by SETDASA, RSTDAA and SETNEWDA strobes
`timescale 1ns/1ps
`default_nettype none

module hci_addr_ctrl (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire hci_pkg::addr_evt_t addr_evt_i,
  output hci_pkg::dev_addr_t      dev_addr_o,
  output hci_pkg::dev_addr_t      virt_addr_o
);

  hci_pkg::dev_addr_t dev_q, virt_q;

  assign dev_addr_o  = dev_q;
  assign virt_addr_o = virt_q;

  // RSTDAA wins over SETDASA, which wins over SETNEWDA
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_q  <= '0;
      virt_q <= '0;
    end else if (addr_evt_i.rstdaa) begin
      dev_q  <= '0;
      virt_q <= '0;
    end else if (addr_evt_i.set_dasa) begin
      if (addr_evt_i.dasa_virt) begin
        virt_q.valid <= 1'b1;
        virt_q.addr  <= addr_evt_i.dasa;
      end else begin
        dev_q.valid <= 1'b1;
        dev_q.addr  <= addr_evt_i.dasa;
      end
    end else if (addr_evt_i.set_newda) begin
      if (addr_evt_i.newda_virt) begin
        virt_q.valid <= 1'b1;
        virt_q.addr  <= addr_evt_i.newda;
      end else begin
        dev_q.valid <= 1'b1;
        dev_q.addr  <= addr_evt_i.newda;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hci_assert.sv ====
// Concurrent checks on the HCI front end ports, bound into hci_top
`timescale 1ns/1ps
`default_nettype none

module hci_assert (
  input wire logic                           clk_i,
  input wire logic                           rst_ni,
  input wire hci_pkg::csr_req_t              csr_req_i,
  input wire hci_pkg::csr_rsp_t              csr_rsp_o,
  input wire logic                           cmd_rvalid_o,
  input wire logic [hci_pkg::HCI_CMD_DW-1:0] cmd_rdata_o,
  input wire logic                           cmd_rready_i,
  input wire logic                           resp_wready_o,
  input wire logic                           cmd_flush
);

  int unsigned violations = 0;  // Failed checks so far
  logic plain_req, known;

  // Port accesses with a variable latency are left out
  assign plain_req = csr_req_i.req &&
      !(csr_req_i.addr == hci_pkg::COMMAND_PORT && csr_req_i.req_is_wr) &&
      !(csr_req_i.addr == hci_pkg::RESPONSE_PORT && !csr_req_i.req_is_wr);
  assign known = csr_req_i.addr inside {hci_pkg::RESET_CONTROL, hci_pkg::QUEUE_THLD_CTRL,
      hci_pkg::COMMAND_PORT, hci_pkg::RESPONSE_PORT, hci_pkg::QUEUE_STATUS,
      hci_pkg::DEVICE_ADDR, hci_pkg::VIRT_DEVICE_ADDR};

  reset_state: assert property (@(posedge clk_i) $rose(rst_ni) |->
      !csr_rsp_o.rd_ack && !csr_rsp_o.wr_ack && !csr_rsp_o.err && !cmd_rvalid_o && resp_wready_o)
    else begin
      $error("Controls not idle after reset");
      violations++;
    end

  acks_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(csr_rsp_o.rd_ack && csr_rsp_o.wr_ack))
    else begin
      $error("rd_ack and wr_ack high together");
      violations++;
    end

  // FWFT output holds while the core stalls
  cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_rvalid_o && !cmd_rready_i && !cmd_flush |=> cmd_rvalid_o && $stable(cmd_rdata_o))
    else begin
      $error("Command output changed before its pop");
      violations++;
    end

  plain_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      plain_req |=> (csr_rsp_o.wr_ack == $past(csr_req_i.req_is_wr)) &&
                    (csr_rsp_o.rd_ack != $past(csr_req_i.req_is_wr)))
    else begin
      $error("Register access not acked on the next cycle");
      violations++;
    end

  err_on_unknown: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_req_i.req |=> (csr_rsp_o.err != $past(known)))
    else begin
      $error("err does not match the address decode");
      violations++;
    end

endmodule

bind hci_top hci_assert u_hci_assert (.*);

`default_nettype wire

// ==== hci_csr.sv ====
// HCI CSR block, decodes CPU accesses and runs the command and response ports
`timescale 1ns/1ps
`default_nettype none

module hci_csr (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire hci_pkg::csr_req_t               csr_req_i,
  input  wire logic                            cmd_full_i,
  input  wire logic                            resp_empty_i,
  input  wire logic [hci_pkg::HCI_RESP_DW-1:0] resp_data_i,
  input  wire logic [hci_pkg::HCI_DEPTH_W-1:0] cmd_count_i,
  input  wire logic [hci_pkg::HCI_DEPTH_W-1:0] resp_count_i,
  input  wire logic                            cmd_flush_done_i,
  input  wire logic                            resp_flush_done_i,
  input  wire hci_pkg::dev_addr_t              dev_addr_i,
  input  wire hci_pkg::dev_addr_t              virt_addr_i,
  output hci_pkg::csr_rsp_t                    csr_rsp_o,
  output logic                                 cmd_push_o,
  output logic      [hci_pkg::HCI_CMD_DW-1:0]  cmd_data_o,
  output logic                                 resp_pop_o,
  output logic                                 cmd_flush_o,
  output logic                                 resp_flush_o,
  output logic      [hci_pkg::HCI_THLD_W-1:0]  cmd_thld_o,
  output logic      [hci_pkg::HCI_THLD_W-1:0]  resp_thld_o
);

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_CMD_WAIT,   // Second word held, waiting for queue room
    PORT_RESP_WAIT   // Read held, waiting for a response
  } port_state_e;

  port_state_e state_q, state_d;
  hci_pkg::csr_rsp_t rsp_q, rsp_d;
  hci_pkg::csr_addr_e addr;
  logic [hci_pkg::HCI_THLD_W-1:0] cmd_thld_q, cmd_thld_d, resp_thld_q, resp_thld_d;
  logic cmd_rst_q, cmd_rst_d, resp_rst_q, resp_rst_d;
  logic half_valid_q, half_valid_d;
  logic [hci_pkg::HCI_CSR_DW-1:0] cmd_lo_q, cmd_hi_q;
  logic lo_we, hi_we;
  logic wr;

  assign addr = hci_pkg::csr_addr_e'(csr_req_i.addr);
  assign wr   = csr_req_i.req_is_wr;

  // Port transfers hold off while a queue reset is pending
  assign cmd_push_o = (state_q == PORT_CMD_WAIT) && !cmd_full_i && !cmd_rst_q;
  assign resp_pop_o = (state_q == PORT_RESP_WAIT) && !resp_empty_i && !resp_rst_q;

  assign cmd_data_o   = {cmd_hi_q, cmd_lo_q};
  assign cmd_flush_o  = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;
  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;
  assign csr_rsp_o    = rsp_q;

  always_comb begin
    state_d      = state_q;
    rsp_d        = '0;
    cmd_thld_d   = cmd_thld_q;
    resp_thld_d  = resp_thld_q;
    cmd_rst_d    = cmd_rst_q & ~cmd_flush_done_i;   // Self-clearing
    resp_rst_d   = resp_rst_q & ~resp_flush_done_i;
    half_valid_d = half_valid_q;
    lo_we        = 1'b0;
    hi_we        = 1'b0;

    if (cmd_push_o) begin
      rsp_d.wr_ack = 1'b1;
      half_valid_d = 1'b0;
      state_d      = PORT_IDLE;
    end
    if (resp_pop_o) begin
      rsp_d.rd_ack  = 1'b1;
      rsp_d.rd_data = resp_data_i;
      state_d       = PORT_IDLE;
    end

    if (csr_req_i.req) begin
      rsp_d.wr_ack = wr;
      rsp_d.rd_ack = !wr;
      case (addr)
        hci_pkg::RESET_CONTROL: begin
          if (wr) begin
            cmd_rst_d  = cmd_rst_d | csr_req_i.wr_data[1];
            resp_rst_d = resp_rst_d | csr_req_i.wr_data[2];
          end else begin
            rsp_d.rd_data = {29'b0, resp_rst_q, cmd_rst_q, 1'b0};
          end
        end
        hci_pkg::QUEUE_THLD_CTRL: begin
          if (wr) begin
            cmd_thld_d  = csr_req_i.wr_data[7:0];
            resp_thld_d = csr_req_i.wr_data[15:8];
          end else begin
            rsp_d.rd_data = {16'b0, resp_thld_q, cmd_thld_q};
          end
        end
        hci_pkg::COMMAND_PORT: begin
          if (wr && half_valid_q) begin
            hi_we        = 1'b1;
            rsp_d.wr_ack = 1'b0;  // Acked once pushed
            state_d      = PORT_CMD_WAIT;
          end else if (wr) begin
            lo_we        = 1'b1;
            half_valid_d = 1'b1;
          end
        end
        hci_pkg::RESPONSE_PORT: begin
          if (!wr) begin
            rsp_d.rd_ack = 1'b0;
            state_d      = PORT_RESP_WAIT;
          end
        end
        hci_pkg::QUEUE_STATUS: rsp_d.rd_data = {20'b0, resp_count_i, 4'b0, cmd_count_i};
        hci_pkg::DEVICE_ADDR: rsp_d.rd_data = {dev_addr_i.valid, 24'b0, dev_addr_i.addr};
        hci_pkg::VIRT_DEVICE_ADDR: rsp_d.rd_data = {virt_addr_i.valid, 24'b0, virt_addr_i.addr};
        default: rsp_d.err = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= PORT_IDLE;
      rsp_q        <= '0;
      cmd_thld_q   <= hci_pkg::HCI_THLD_W'(1);
      resp_thld_q  <= hci_pkg::HCI_THLD_W'(1);
      cmd_rst_q    <= 1'b0;
      resp_rst_q   <= 1'b0;
      half_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      rsp_q        <= rsp_d;
      cmd_thld_q   <= cmd_thld_d;
      resp_thld_q  <= resp_thld_d;
      cmd_rst_q    <= cmd_rst_d;
      resp_rst_q   <= resp_rst_d;
      half_valid_q <= half_valid_d;
    end
  end

  // Command words
  always_ff @(posedge clk_i) begin
    if (lo_we) begin
      cmd_lo_q <= csr_req_i.wr_data;
    end
    if (hi_we) begin
      cmd_hi_q <= csr_req_i.wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== hci_pkg.sv ====
// I3C HCI front end shared definitions
// Sizes, register map, queue roles and port structs
`default_nettype none

package hci_pkg;

  localparam int unsigned HCI_CSR_DW      = 32;
  localparam int unsigned HCI_CSR_AW      = 8;
  localparam int unsigned HCI_CMD_DW      = 64;
  localparam int unsigned HCI_RESP_DW     = 32;
  localparam int unsigned HCI_QUEUE_DEPTH = 8;
  localparam int unsigned HCI_DEPTH_W     = 4;  // Entry count, 0..8
  localparam int unsigned HCI_THLD_W      = 8;
  localparam int unsigned HCI_ADDR_W      = 7;

  // Register map, byte addresses
  typedef enum logic [HCI_CSR_AW-1:0] {
    RESET_CONTROL    = 8'h10,
    QUEUE_THLD_CTRL  = 8'h14,
    COMMAND_PORT     = 8'h18,
    RESPONSE_PORT    = 8'h1C,
    QUEUE_STATUS     = 8'h20,
    DEVICE_ADDR      = 8'h24,
    VIRT_DEVICE_ADDR = 8'h28
  } csr_addr_e;

  // Command queue triggers on free space, response queue on fill level
  typedef enum logic {
    Q_CMD,
    Q_RESP
  } queue_role_e;

  typedef struct packed {
    logic                  req;
    logic                  req_is_wr;
    logic [HCI_CSR_AW-1:0] addr;
    logic [HCI_CSR_DW-1:0] wr_data;
  } csr_req_t;

  typedef struct packed {
    logic                  rd_ack;
    logic                  wr_ack;
    logic                  err;
    logic [HCI_CSR_DW-1:0] rd_data;
  } csr_rsp_t;

  // Single-cycle CCC strobes from the controller core
  typedef struct packed {
    logic                  set_dasa;
    logic [HCI_ADDR_W-1:0] dasa;
    logic                  dasa_virt;
    logic                  rstdaa;
    logic                  set_newda;
    logic [HCI_ADDR_W-1:0] newda;
    logic                  newda_virt;
  } addr_evt_t;

  typedef struct packed {
    logic                  valid;
    logic [HCI_ADDR_W-1:0] addr;
  } dev_addr_t;

endpackage

`default_nettype wire

// ==== hci_queue.sv ====
// HCI queue, circular FIFO with ready-threshold trigger and software flush
`timescale 1ns/1ps
`default_nettype none

module hci_queue #(
  parameter hci_pkg::queue_role_e Role      = hci_pkg::Q_CMD,
  parameter int unsigned          DataWidth = 64
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           push_i,
  input  wire logic [DataWidth-1:0]           data_i,
  input  wire logic                           pop_i,
  input  wire logic                           flush_i,
  input  wire logic [hci_pkg::HCI_THLD_W-1:0] thld_i,
  output logic      [DataWidth-1:0]           data_o,
  output logic                                full_o,
  output logic                                empty_o,
  output logic      [hci_pkg::HCI_DEPTH_W-1:0] count_o,
  output logic                                thld_trig_o,
  output logic                                flush_done_o
);

  logic [DataWidth-1:0] mem_q [hci_pkg::HCI_QUEUE_DEPTH];
  logic [hci_pkg::HCI_DEPTH_W-2:0] wr_ptr_q, rd_ptr_q;
  logic [hci_pkg::HCI_DEPTH_W-1:0] count_q;
  logic [hci_pkg::HCI_DEPTH_W-1:0] level;
  logic [hci_pkg::HCI_THLD_W-1:0] thld_eff;
  logic push, pop;

  assign full_o  = (count_q == hci_pkg::HCI_DEPTH_W'(hci_pkg::HCI_QUEUE_DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];  // First word falls through

  // Traffic in the flush cycle is dropped
  assign push = push_i && !full_o && !flush_i;
  assign pop  = pop_i && !empty_o && !flush_i;

  // Flush completes in the cycle it is seen
  assign flush_done_o = flush_i;

  assign thld_eff = (thld_i == '0) ? hci_pkg::HCI_THLD_W'(1) : thld_i;

  always_comb begin
    if (Role == hci_pkg::Q_CMD) begin
      level = hci_pkg::HCI_DEPTH_W'(hci_pkg::HCI_QUEUE_DEPTH) - count_q;  // Free entries
    end else begin
      level = count_q;
    end
  end

  assign thld_trig_o = (hci_pkg::HCI_THLD_W'(level) >= thld_eff);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hci_top.f ====
hci_pkg.sv
hci_queue.sv
hci_addr_ctrl.sv
hci_csr.sv
hci_top.sv
hci_assert.sv
tb_hci_top.sv

// ==== hci_top.sv ====
// I3C HCI front end top, CSR block with command and response queues
// and the dynamic address unit
`timescale 1ns/1ps
`default_nettype none

module hci_top (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire hci_pkg::csr_req_t               csr_req_i,
  input  wire logic                            cmd_rready_i,
  input  wire logic                            resp_wvalid_i,
  input  wire logic [hci_pkg::HCI_RESP_DW-1:0] resp_wdata_i,
  input  wire hci_pkg::addr_evt_t              addr_evt_i,
  output hci_pkg::csr_rsp_t                    csr_rsp_o,
  output logic                                 cmd_rvalid_o,
  output logic      [hci_pkg::HCI_CMD_DW-1:0]  cmd_rdata_o,
  output logic                                 resp_wready_o,
  output logic                                 cmd_thld_trig_o,
  output logic                                 resp_thld_trig_o,
  output hci_pkg::dev_addr_t                   dev_addr_o,
  output hci_pkg::dev_addr_t                   virt_addr_o
);

  logic cmd_push, cmd_full, cmd_empty, cmd_flush, cmd_flush_done;
  logic resp_pop, resp_full, resp_empty, resp_flush, resp_flush_done;
  logic [hci_pkg::HCI_CMD_DW-1:0] cmd_wdata;
  logic [hci_pkg::HCI_RESP_DW-1:0] resp_rdata;
  logic [hci_pkg::HCI_DEPTH_W-1:0] cmd_count, resp_count;
  logic [hci_pkg::HCI_THLD_W-1:0] cmd_thld, resp_thld;

  assign cmd_rvalid_o  = !cmd_empty;
  assign resp_wready_o = !resp_full;

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .cmd_full_i        (cmd_full),
    .resp_empty_i      (resp_empty),
    .resp_data_i       (resp_rdata),
    .cmd_count_i       (cmd_count),
    .resp_count_i      (resp_count),
    .cmd_flush_done_i  (cmd_flush_done),
    .resp_flush_done_i (resp_flush_done),
    .dev_addr_i        (dev_addr_o),
    .virt_addr_i       (virt_addr_o),
    .csr_rsp_o,
    .cmd_push_o        (cmd_push),
    .cmd_data_o        (cmd_wdata),
    .resp_pop_o        (resp_pop),
    .cmd_flush_o       (cmd_flush),
    .resp_flush_o      (resp_flush),
    .cmd_thld_o        (cmd_thld),
    .resp_thld_o       (resp_thld)
  );

  hci_queue #(
    .Role      (hci_pkg::Q_CMD),
    .DataWidth (hci_pkg::HCI_CMD_DW)
  ) u_cmd_queue (
    .clk_i,
    .rst_ni,
    .push_i       (cmd_push),
    .data_i       (cmd_wdata),
    .pop_i        (cmd_rready_i),
    .flush_i      (cmd_flush),
    .thld_i       (cmd_thld),
    .data_o       (cmd_rdata_o),
    .full_o       (cmd_full),
    .empty_o      (cmd_empty),
    .count_o      (cmd_count),
    .thld_trig_o  (cmd_thld_trig_o),
    .flush_done_o (cmd_flush_done)
  );

  hci_queue #(
    .Role      (hci_pkg::Q_RESP),
    .DataWidth (hci_pkg::HCI_RESP_DW)
  ) u_resp_queue (
    .clk_i,
    .rst_ni,
    .push_i       (resp_wvalid_i),
    .data_i       (resp_wdata_i),
    .pop_i        (resp_pop),
    .flush_i      (resp_flush),
    .thld_i       (resp_thld),
    .data_o       (resp_rdata),
    .full_o       (resp_full),
    .empty_o      (resp_empty),
    .count_o      (resp_count),
    .thld_trig_o  (resp_thld_trig_o),
    .flush_done_o (resp_flush_done)
  );

  hci_addr_ctrl u_addr_ctrl (
    .clk_i,
    .rst_ni,
    .addr_evt_i,
    .dev_addr_o,
    .virt_addr_o
  );

endmodule

`default_nettype wire

// ==== tb_hci_top.sv ====
// Testbench for the I3C HCI front end
`timescale 1ns/1ps
`default_nettype none

module tb_hci_top;

  localparam int MAX_CYCLES = 2000;

  logic clk_i = 1'b0;
  logic rst_ni, cmd_rready_i, resp_wvalid_i, cmd_rvalid_o, resp_wready_o;
  logic cmd_thld_trig_o, resp_thld_trig_o;
  logic [31:0] resp_wdata_i;
  logic [63:0] cmd_rdata_o;
  hci_pkg::csr_req_t csr_req_i;
  hci_pkg::csr_rsp_t csr_rsp_o;
  hci_pkg::addr_evt_t addr_evt_i;
  hci_pkg::dev_addr_t dev_addr_o, virt_addr_o, dev_m, virt_m;
  logic [63:0] cmd_m [$];  // Reference queues
  logic [31:0] resp_m [$];
  int cmd_thld, resp_thld;
  int cycles = 0;

  hci_top UUT (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  always @(UUT.u_hci_assert.violations) begin
    if (UUT.u_hci_assert.violations != 0) begin
      $display("A concurrent assertion on hci_top failed");
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failed");
    end
  end

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic expect_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // One CPU access held until its ack
  task automatic csr_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    csr_req_i = '{req: 1'b1, req_is_wr: wr, addr: addr, wr_data: wdata};
    tick();
    csr_req_i.req = 1'b0;
    while (!(wr ? csr_rsp_o.wr_ack : csr_rsp_o.rd_ack)) tick();
    rdata = csr_rsp_o.rd_data;
    err = csr_rsp_o.err;
  endtask

  task automatic csr_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic err;
    csr_access(1'b1, addr, wdata, rdata, err);
    expect_val(err, 1'b0, "write err");
  endtask

  task automatic csr_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic err;
    csr_access(1'b0, addr, '0, rdata, err);
    expect_val(err, 1'b0, "read err");
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rdata;
    csr_read(addr, rdata);
    expect_val(rdata, exp, what);
  endtask

  task automatic write_cmd(input logic [63:0] cmd);
    cmd_m.push_back(cmd);
    csr_write(hci_pkg::COMMAND_PORT, cmd[31:0]);  // Low word first
    csr_write(hci_pkg::COMMAND_PORT, cmd[63:32]);
  endtask

  // Random ready gaps with every pop checked against the model
  task automatic drain_cmds(input int n);
    while (n > 0) begin
      cmd_rready_i = ($urandom % 2) == 1;
      if (cmd_rready_i && cmd_rvalid_o) begin
        expect_val(cmd_rdata_o, cmd_m.pop_front(), "cmd_rdata_o");
        n--;
      end
      tick();
    end
    cmd_rready_i = 1'b0;
  endtask

  task automatic push_resp(input logic [31:0] data);
    expect_val(resp_wready_o, 1'b1, "resp_wready_o");
    resp_wvalid_i = 1'b1;
    resp_wdata_i = data;
    resp_m.push_back(data);
    tick();
    resp_wvalid_i = 1'b0;
  endtask

  task automatic set_thld(input int c, input int r);
    cmd_thld = c;
    resp_thld = r;
    csr_write(hci_pkg::QUEUE_THLD_CTRL, (r << 8) | c);
  endtask

  // Zero threshold acts as one
  task automatic check_trig();
    int c_eff, r_eff;
    c_eff = (cmd_thld == 0) ? 1 : cmd_thld;
    r_eff = (resp_thld == 0) ? 1 : resp_thld;
    expect_val(cmd_thld_trig_o, (8 - cmd_m.size()) >= c_eff, "cmd_thld_trig_o");
    expect_val(resp_thld_trig_o, resp_m.size() >= r_eff, "resp_thld_trig_o");
    read_expect(hci_pkg::QUEUE_STATUS, (resp_m.size() << 8) | cmd_m.size(), "QUEUE_STATUS");
  endtask

  function automatic hci_pkg::addr_evt_t make_evt(logic dasa, logic newda, logic rst, logic virt);
    return '{set_dasa: dasa, dasa: 7'($urandom), dasa_virt: virt, rstdaa: rst,
             set_newda: newda, newda: 7'($urandom), newda_virt: virt};
  endfunction

  // RSTDAA over SETDASA over SETNEWDA
  task automatic apply_evt(input hci_pkg::addr_evt_t evt);
    if (evt.rstdaa) begin
      dev_m = '0;
      virt_m = '0;
    end else if (evt.set_dasa && evt.dasa_virt) begin
      virt_m = '{valid: 1'b1, addr: evt.dasa};
    end else if (evt.set_dasa) begin
      dev_m = '{valid: 1'b1, addr: evt.dasa};
    end else if (evt.set_newda && evt.newda_virt) begin
      virt_m = '{valid: 1'b1, addr: evt.newda};
    end else if (evt.set_newda) begin
      dev_m = '{valid: 1'b1, addr: evt.newda};
    end
    addr_evt_i = evt;
    tick();
    addr_evt_i = '0;
    expect_val(dev_addr_o, dev_m, "dev_addr_o");
    expect_val(virt_addr_o, virt_m, "virt_addr_o");
    read_expect(hci_pkg::DEVICE_ADDR, {dev_m.valid, 24'b0, dev_m.addr}, "DEVICE_ADDR");
    read_expect(hci_pkg::VIRT_DEVICE_ADDR, {virt_m.valid, 24'b0, virt_m.addr}, "VIRT_DEVICE_ADDR");
  endtask

  initial begin
    logic [63:0] cmd;
    logic [31:0] rdata;
    logic err, acked;
    void'($urandom(88438));
    rst_ni = 1'b0;
    csr_req_i = '0;
    cmd_rready_i = 1'b0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i = '0;
    addr_evt_i = '0;
    dev_m = '0;
    virt_m = '0;
    cmd_thld = 1;
    resp_thld = 1;
    repeat (3) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    tick();
    read_expect(hci_pkg::QUEUE_THLD_CTRL, 32'h0101, "QUEUE_THLD_CTRL after reset");
    read_expect(hci_pkg::RESET_CONTROL, 32'h0, "RESET_CONTROL after reset");
    check_trig();

    // Commands against a stalling core and then a full queue
    fork
      repeat (6) write_cmd({$urandom, $urandom});
      drain_cmds(6);
    join
    repeat (8) write_cmd({$urandom, $urandom});
    check_trig();
    cmd = {$urandom, $urandom};
    cmd_m.push_back(cmd);
    csr_write(hci_pkg::COMMAND_PORT, cmd[31:0]);
    acked = 1'b0;
    fork
      begin
        csr_write(hci_pkg::COMMAND_PORT, cmd[63:32]);
        acked = 1'b1;
      end
      begin
        repeat (5) tick();
        expect_val(acked, 1'b0, "ack of a command into a full queue");
        drain_cmds(9);
      end
    join

    // Responses with a first read that waits on an empty queue
    acked = 1'b0;
    fork
      begin
        csr_read(hci_pkg::RESPONSE_PORT, rdata);
        acked = 1'b1;
      end
      begin
        repeat (4) tick();
        expect_val(acked, 1'b0, "ack of a read from an empty queue");
        push_resp($urandom);
      end
    join
    expect_val(rdata, resp_m.pop_front(), "RESPONSE_PORT");
    repeat (8) push_resp($urandom);
    expect_val(resp_wready_o, 1'b0, "resp_wready_o when full");
    check_trig();
    repeat (8) read_expect(hci_pkg::RESPONSE_PORT, resp_m.pop_front(), "RESPONSE_PORT");

    // Thresholds while filling and draining
    set_thld(3, 2);
    check_trig();
    repeat (6) begin
      write_cmd({$urandom, $urandom});
      check_trig();
    end
    repeat (3) begin
      push_resp($urandom);
      check_trig();
    end
    repeat (3) begin
      drain_cmds(1);
      check_trig();
    end
    repeat (2) begin
      read_expect(hci_pkg::RESPONSE_PORT, resp_m.pop_front(), "RESPONSE_PORT");
      check_trig();
    end
    set_thld(0, 0);
    check_trig();
    read_expect(hci_pkg::RESPONSE_PORT, resp_m.pop_front(), "RESPONSE_PORT");
    check_trig();

    // Queue resets where the flush lands one edge after the ack
    repeat (2) push_resp($urandom);
    csr_write(hci_pkg::RESET_CONTROL, 32'h6);
    tick();
    cmd_m.delete();
    resp_m.delete();
    read_expect(hci_pkg::RESET_CONTROL, 32'h0, "RESET_CONTROL after flush");
    check_trig();
    expect_val(cmd_rvalid_o, 1'b0, "cmd_rvalid_o after flush");

    apply_evt(make_evt(1'b1, 1'b0, 1'b0, 1'b0));
    apply_evt(make_evt(1'b1, 1'b0, 1'b0, 1'b1));
    apply_evt(make_evt(1'b0, 1'b1, 1'b0, 1'b0));
    apply_evt(make_evt(1'b0, 1'b1, 1'b0, 1'b1));
    apply_evt(make_evt(1'b1, 1'b1, 1'b0, 1'b0));
    apply_evt(make_evt(1'b1, 1'b0, 1'b1, 1'b0));
    apply_evt(make_evt(1'b1, 1'b0, 1'b0, 1'b1));

    // Unknown addresses
    push_resp($urandom);
    csr_access(1'b0, 8'h30, '0, rdata, err);
    expect_val(err, 1'b1, "err on unknown read");
    csr_access(1'b1, 8'h04, 32'hFFFF_FFFF, rdata, err);
    expect_val(err, 1'b1, "err on unknown write");
    read_expect(hci_pkg::QUEUE_THLD_CTRL, 32'h0, "QUEUE_THLD_CTRL after unknown write");
    check_trig();  // Queues keep their entries
    apply_evt('0);

    tick();
    if (UUT.u_hci_assert.violations == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failed");
    end
  end

endmodule

`default_nettype wire
